// File: filelist.f
+incdir+include
hw/cache_pkg.sv
hw/sync_ram.sv
hw/tag_store.sv
hw/data_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
tests/cache_assertions.sv
tests/cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/cache_tb.sv
// --------------------------------------------------
// Data cache testbench
// --------------------------------------------------
bind cache_top cache_assertions i_assertions (
    .clk    (clk),
    .reset  (reset),
    .addr_ok(addr_ok),
    .data_ok(data_ok),
    .rd_req (rd_req),
    .rd_rdy (rd_rdy),
    .wr_req (wr_req)
);

module cache_tb;

    import cache_pkg::*;

    logic clk;
    logic reset;
    logic valid;
    cpu_req_t req;
    logic addr_ok;
    logic data_ok;
    word_t rdata;
    logic rd_req;
    logic [31:0] rd_addr;
    logic rd_rdy;
    logic ret_valid;
    logic ret_last;
    word_t ret_data;
    logic wr_req;
    logic [31:0] wr_addr;
    block_t wr_data;
    logic wr_rdy;

    integer seed;
    int errors;
    int checks;
    int cycle;
    int rd_count;
    int wb_count;
    int event_seq;
    int last_rd_seq;
    int last_wb_seq;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wb_addr;
    block_t last_wb_data;
    // bus-side memory and the values the CPU should see
    logic [31:0] shadow [logic [31:0]];
    logic [31:0] ref_mem [logic [31:0]];

    cache_top i_dut (
        .clk(clk), .reset(reset), .valid(valid), .req(req),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] mem_word(logic [31:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] ref_word(logic [31:0] a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] apply_strobe(logic [31:0] old, logic [31:0] upd,
                                                 logic [3:0] strobe);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strobe[i]) begin
                res[8*i +: 8] = upd[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_eq(string name, logic [127:0] got, logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic abort(string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    task automatic report(string name, int errs_before);
        $display("%s finished with %0d errors", name, errors - errs_before);
    endtask

    // one CPU request; reads are checked against the expected memory
    task automatic cpu_access(input bit op, input logic [31:0] addr, input logic [3:0] strobe,
                              input word_t wdata, output int lat);
        int n;
        int start;
        logic [31:0] wa;
        wa = {addr[31:2], 2'b00};
        @(posedge clk);
        #10;
        valid = 1'b1;
        req = '{op: op, index: addr[11:4], tag: addr[31:12], offset: addr[3:0],
                wstrb: strobe, wdata: wdata};
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 50) abort("addr_ok never came");
        end while (!addr_ok);
        start = cycle;
        @(posedge clk);
        #10;
        valid = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 300) abort("data_ok never came");
        end while (!data_ok);
        lat = cycle - start;
        if (op) begin
            ref_mem[wa] = apply_strobe(ref_word(wa), wdata, strobe);
        end else begin
            check_eq("rdata", rdata, ref_word(wa));
        end
    endtask

    // bus memory model with random handshake delays and beat gaps
    task automatic bus_delay();
        int d;
        d = $unsigned($random(seed)) % 4;
        repeat (d) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic serve_read();
        logic [31:0] base;
        base = rd_addr;
        rd_count++;
        event_seq++;
        last_rd_seq = event_seq;
        last_rd_addr = base;
        bus_delay();
        @(posedge clk);
        #10 rd_rdy = 1'b1;
        @(posedge clk);
        #10 rd_rdy = 1'b0;
        for (int b = 0; b < 4; b++) begin
            bus_delay();
            ret_valid = 1'b1;
            ret_data = mem_word(base + 32'(4 * b));
            ret_last = (b == 3);
            @(posedge clk);
            #10;
            ret_valid = 1'b0;
            ret_last = 1'b0;
        end
    endtask

    task automatic serve_write();
        wb_count++;
        event_seq++;
        last_wb_seq = event_seq;
        last_wb_addr = wr_addr;
        last_wb_data = wr_data;
        bus_delay();
        @(posedge clk);
        #10 wr_rdy = 1'b1;
        @(posedge clk);
        #10 wr_rdy = 1'b0;
        for (int b = 0; b < 4; b++) begin
            shadow[last_wb_addr + 32'(4 * b)] = last_wb_data[b];
        end
    endtask

    initial begin
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        wr_rdy = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset && rd_req) begin
                serve_read();
            end else if (!reset && wr_req) begin
                serve_write();
            end
        end
    end

    task automatic test_cold_read();
        int e;
        int lat;
        int rc;
        e = errors;
        @(negedge clk);
        check_eq("addr_ok", addr_ok, 0);
        check_eq("data_ok", data_ok, 0);
        check_eq("rd_req", rd_req, 0);
        check_eq("wr_req", wr_req, 0);
        rc = rd_count;
        cpu_access(0, 32'h0001_2348, 4'h0, '0, lat);
        check_eq("rd_count", rd_count, rc + 1);
        check_eq("rd_addr", last_rd_addr, 32'h0001_2340);
        report("cold read", e);
    endtask

    task automatic test_read_hit();
        int e;
        int lat;
        int rc;
        e = errors;
        rc = rd_count;
        cpu_access(0, 32'h0001_234c, 4'h0, '0, lat);
        check_eq("read hit latency", lat, 1);
        check_eq("rd_count", rd_count, rc);
        report("read hit", e);
    endtask

    task automatic test_write_hit();
        int e;
        int lat;
        e = errors;
        cpu_access(1, 32'h0001_2344, 4'b0101, 32'hdead_beef, lat);
        check_eq("write hit latency", lat, 2);
        cpu_access(0, 32'h0001_2344, 4'h0, '0, lat);
        // bytes 0 and 2 from the store, bytes 1 and 3 from memory word 5a5b2344
        check_eq("merged word", rdata, 32'h5aad_23ef);
        report("write hit", e);
    endtask

    task automatic test_write_miss();
        int e;
        int lat;
        int rc;
        e = errors;
        rc = rd_count;
        cpu_access(1, 32'h0004_5678, 4'b1100, 32'hcafe_f00d, lat);
        check_eq("rd_count", rd_count, rc + 1);
        check_eq("rd_addr", last_rd_addr, 32'h0004_5670);
        cpu_access(0, 32'h0004_5678, 4'h0, '0, lat);
        cpu_access(0, 32'h0004_567c, 4'h0, '0, lat);
        report("write miss", e);
    endtask

    task automatic test_eviction();
        int e;
        int lat;
        int wc;
        block_t exp_block;
        e = errors;
        // line A sits in way 0 and is dirty; the hit leaves way 1 as LRU
        cpu_access(0, 32'h0001_2340, 4'h0, '0, lat);
        check_eq("hit latency", lat, 1);
        wc = wb_count;
        for (int b = 0; b < 4; b++) begin
            exp_block[b] = ref_word(32'h0001_2340 + 32'(4 * b));
        end
        // fills the empty way 1, nothing written back
        cpu_access(0, 32'h0010_0344, 4'h0, '0, lat);
        check_eq("wb_count", wb_count, wc);
        // way 0 is LRU now, dirty line A goes out first
        cpu_access(0, 32'h0020_0348, 4'h0, '0, lat);
        check_eq("wb_count", wb_count, wc + 1);
        check_eq("wr_addr", last_wb_addr, 32'h0001_2340);
        check_eq("wr_data", last_wb_data, exp_block);
        checks++;
        assert (last_wb_seq < last_rd_seq) else begin
            $display("Error at %0t: refill read came before the write-back", $time);
            errors++;
        end
        // clean victims from here on
        cpu_access(0, 32'h0030_034c, 4'h0, '0, lat);
        cpu_access(0, 32'h0001_2344, 4'h0, '0, lat);
        check_eq("wb_count", wb_count, wc + 1);
        report("eviction", e);
    endtask

    initial begin
        seed = 32'hc32e;
        errors = 0;
        checks = 0;
        rd_count = 0;
        wb_count = 0;
        event_seq = 0;
        valid = 1'b0;
        req = '0;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #10 reset = 1'b0;
        test_cold_read();
        test_read_hit();
        test_write_hit();
        test_write_miss();
        test_eviction();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tests/cache_assertions.sv
// --------------------------------------------------
// Cache bus and handshake assertions
// --------------------------------------------------
module cache_assertions (
    input logic clk,
    input logic reset,
    input logic addr_ok,
    input logic data_ok,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req
);

    // a request was taken and its data_ok is still owed
    logic pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (addr_ok) begin
            pending <= 1'b1;
        end else if (data_ok) begin
            pending <= 1'b0;
        end
    end

    a_one_bus_req: assert property (@(posedge clk) disable iff (reset) !(rd_req && wr_req))
        else $error("rd_req and wr_req high together");

    a_rd_req_held: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    a_data_ok_owed: assert property (@(posedge clk) disable iff (reset) data_ok |-> pending)
        else $error("data_ok without an accepted request");

    a_quiet_after_reset: assert property (@(posedge clk)
        reset |=> !data_ok && !rd_req && !wr_req)
        else $error("activity in the cycle after reset");

endmodule

// File: hw/cache_top.sv
// --------------------------------------------------
// Data cache top level
// --------------------------------------------------
`include "cache_params.svh"

module cache_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  cache_pkg::cpu_req_t  req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output cache_pkg::word_t     rdata,
    output logic                 rd_req,
    output logic [31:0]          rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  cache_pkg::word_t     ret_data,
    output logic                 wr_req,
    output logic [31:0]          wr_addr,
    output cache_pkg::block_t    wr_data,
    input  logic                 wr_rdy
);

    import cache_pkg::*;

    tag_cmd_t                          tag_cmd;
    logic [`CACHE_TAG_W-1:0]           lookup_tag;
    logic                              hit;
    logic                              hit_way;
    logic                              victim_way;
    logic                              victim_dirty;
    logic [`CACHE_TAG_W-1:0]           victim_tag;
    logic [`CACHE_INDEX_W-1:0]         data_index;
    logic                              data_rd_en;
    logic                              data_wr_en;
    logic                              data_way;
    logic [$clog2(`CACHE_BANKS)-1:0]   data_bank;
    logic [3:0]                        data_byte_en;
    word_t                             data_wdata;
    block_t                            way0_block;
    block_t                            way1_block;
    wb_req_t                           wb;

    cache_ctrl i_ctrl (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .req         (req),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .tag_cmd     (tag_cmd),
        .lookup_tag  (lookup_tag),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag),
        .data_index  (data_index),
        .data_rd_en  (data_rd_en),
        .data_wr_en  (data_wr_en),
        .data_way    (data_way),
        .data_bank   (data_bank),
        .data_byte_en(data_byte_en),
        .data_wdata  (data_wdata),
        .way0_block  (way0_block),
        .way1_block  (way1_block),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .wr_req      (wr_req),
        .wb          (wb),
        .wr_rdy      (wr_rdy)
    );

    tag_store i_tag_store (
        .clk         (clk),
        .reset       (reset),
        .cmd         (tag_cmd),
        .lookup_tag  (lookup_tag),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag)
    );

    data_store i_data_store (
        .clk       (clk),
        .index     (data_index),
        .rd_en     (data_rd_en),
        .wr_en     (data_wr_en),
        .way       (data_way),
        .bank      (data_bank),
        .byte_en   (data_byte_en),
        .wdata     (data_wdata),
        .way0_block(way0_block),
        .way1_block(way1_block)
    );

    // write-back request split onto the bus
    assign wr_addr = wb.addr;
    assign wr_data = wb.data;

endmodule

// File: hw/cache_ctrl.sv
// --------------------------------------------------
// Cache controller FSM
// --------------------------------------------------
`include "cache_params.svh"

module cache_ctrl (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              valid,
    input  cache_pkg::cpu_req_t               req,
    output logic                              addr_ok,
    output logic                              data_ok,
    output cache_pkg::word_t                  rdata,
    output cache_pkg::tag_cmd_t               tag_cmd,
    output logic [`CACHE_TAG_W-1:0]           lookup_tag,
    input  logic                              hit,
    input  logic                              hit_way,
    input  logic                              victim_way,
    input  logic                              victim_dirty,
    input  logic [`CACHE_TAG_W-1:0]           victim_tag,
    output logic [`CACHE_INDEX_W-1:0]         data_index,
    output logic                              data_rd_en,
    output logic                              data_wr_en,
    output logic                              data_way,
    output logic [$clog2(`CACHE_BANKS)-1:0]   data_bank,
    output logic [3:0]                        data_byte_en,
    output cache_pkg::word_t                  data_wdata,
    input  cache_pkg::block_t                 way0_block,
    input  cache_pkg::block_t                 way1_block,
    output logic                              rd_req,
    output logic [31:0]                       rd_addr,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  logic                              ret_last,
    input  cache_pkg::word_t                  ret_data,
    output logic                              wr_req,
    output cache_pkg::wb_req_t                wb,
    input  logic                              wr_rdy
);

    import cache_pkg::*;

    localparam int bank_w = $clog2(`CACHE_BANKS);

    typedef enum logic [2:0] {
        IDLE, LOOKUP, WRITEHIT, MISS, WRITEBACK, REFILL
    } state_t;

    state_t            state;
    state_t            state_next;
    cpu_req_t          req_q;
    logic [bank_w-1:0] beat_q;
    logic [bank_w-1:0] req_bank;
    logic              target_beat;
    logic              fill_done;
    block_t            hit_block;
    block_t            victim_block;
    word_t             refill_word;

    assign req_bank    = req_q.offset[`CACHE_OFFSET_W-1 -: bank_w];
    assign target_beat = (state == REFILL) && ret_valid && (beat_q == req_bank);
    assign fill_done   = (state == REFILL) && ret_valid && ret_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (valid) state_next = LOOKUP;
            LOOKUP: begin
                if (!hit) begin
                    state_next = MISS;
                end else if (req_q.op) begin
                    state_next = WRITEHIT;
                end else begin
                    state_next = IDLE;
                end
            end
            WRITEHIT:  state_next = IDLE;
            // dirty victim goes out first, then back here with it clean
            MISS: begin
                if (victim_dirty) begin
                    state_next = WRITEBACK;
                end else if (rd_rdy) begin
                    state_next = REFILL;
                end
            end
            WRITEBACK: if (wr_rdy) state_next = MISS;
            REFILL:    if (fill_done) state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_q <= req;
        end
    end

    // refill beat counter, bank 0 arrives first
    always_ff @(posedge clk) begin
        if (reset || state != REFILL) begin
            beat_q <= '0;
        end else if (ret_valid) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    assign addr_ok    = (state == IDLE) && valid;
    assign lookup_tag = req_q.tag;

    // store bytes land on the beat that carries the requested word
    assign refill_word = (req_q.op && beat_q == req_bank) ?
                         merge_word(ret_data, req_q.wdata, req_q.wstrb) : ret_data;

    always_comb begin
        tag_cmd.rd_en     = addr_ok;
        tag_cmd.index     = data_index;
        tag_cmd.fill_we   = fill_done;
        tag_cmd.fill_tag  = req_q.tag;
        tag_cmd.set_dirty = (state == WRITEHIT) || (fill_done && req_q.op);
        tag_cmd.clr_dirty = ((state == WRITEBACK) && wr_rdy) || (fill_done && !req_q.op);
        tag_cmd.touch_lru = ((state == LOOKUP) && hit) || fill_done;
        tag_cmd.way       = (state == LOOKUP || state == WRITEHIT) ? hit_way : victim_way;
    end

    assign data_index   = (state == IDLE) ? req.index : req_q.index;
    assign data_rd_en   = addr_ok;
    assign data_wr_en   = (state == WRITEHIT) || ((state == REFILL) && ret_valid);
    assign data_way     = (state == WRITEHIT) ? hit_way : victim_way;
    assign data_bank    = (state == WRITEHIT) ? req_bank : beat_q;
    assign data_byte_en = (state == WRITEHIT) ? req_q.wstrb : 4'hf;
    assign data_wdata   = (state == WRITEHIT) ? req_q.wdata : refill_word;

    assign hit_block    = hit_way ? way1_block : way0_block;
    assign victim_block = victim_way ? way1_block : way0_block;

    assign data_ok = ((state == LOOKUP) && hit && !req_q.op) ||
                     (state == WRITEHIT) || target_beat;
    assign rdata   = (state == REFILL) ? ret_data : hit_block[req_bank];

    assign rd_req  = (state == MISS) && !victim_dirty;
    assign rd_addr = {req_q.tag, req_q.index, {`CACHE_OFFSET_W{1'b0}}};

    assign wr_req  = (state == WRITEBACK);
    assign wb      = '{addr: {victim_tag, req_q.index, {`CACHE_OFFSET_W{1'b0}}},
                       data: victim_block};

endmodule

// File: hw/data_store.sv
// --------------------------------------------------
// Data banks for both ways
// --------------------------------------------------
`include "cache_params.svh"

module data_store (
    input  logic                              clk,
    input  logic [`CACHE_INDEX_W-1:0]         index,
    input  logic                              rd_en,
    input  logic                              wr_en,
    input  logic                              way,
    input  logic [$clog2(`CACHE_BANKS)-1:0]   bank,
    input  logic [3:0]                        byte_en,
    input  cache_pkg::word_t                  wdata,
    output cache_pkg::block_t                 way0_block,
    output cache_pkg::block_t                 way1_block
);

    import cache_pkg::*;

    localparam int bank_w = $clog2(`CACHE_BANKS);

    block_t way_block [2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
            logic  sel;
            word_t merged;

            assign sel = wr_en && (way == 1'(w)) && (bank == bank_w'(b));

            // bytes left out of byte_en keep the word read last
            assign merged = merge_word(way_block[w][b], wdata, byte_en);

            sync_ram #(
                .payload_t(word_t),
                .depth    (`CACHE_SETS)
            ) i_bank_ram (
                .clk  (clk),
                .en   (rd_en || sel),
                .we   (sel),
                .addr (index),
                .wdata(merged),
                .rdata(way_block[w][b])
            );
        end
    end

    assign way0_block = way_block[0];
    assign way1_block = way_block[1];

endmodule

// File: hw/tag_store.sv
// --------------------------------------------------
// Tag, dirty and LRU state
// --------------------------------------------------
`include "cache_params.svh"

module tag_store (
    input  logic                     clk,
    input  logic                     reset,
    input  cache_pkg::tag_cmd_t      cmd,
    input  logic [`CACHE_TAG_W-1:0]  lookup_tag,
    output logic                     hit,
    output logic                     hit_way,
    output logic                     victim_way,
    output logic                     victim_dirty,
    output logic [`CACHE_TAG_W-1:0]  victim_tag
);

    import cache_pkg::*;

    tagv_t                     tagv_rd [2];
    tagv_t                     fill_entry;
    logic [1:0]                way_hit;
    logic [1:0][`CACHE_SETS-1:0] dirty;
    // lru[set] holds the way to evict next
    logic [`CACHE_SETS-1:0]    lru;
    logic [`CACHE_INDEX_W-1:0] index_q;

    assign fill_entry = '{tag: cmd.fill_tag, valid: 1'b1};

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic ram_we;

        assign ram_we = cmd.fill_we && (cmd.way == 1'(w));

        sync_ram #(
            .payload_t(tagv_t),
            .depth    (`CACHE_SETS)
        ) i_tagv_ram (
            .clk  (clk),
            .en   (cmd.rd_en || ram_we),
            .we   (ram_we),
            .addr (cmd.index),
            .wdata(fill_entry),
            .rdata(tagv_rd[w])
        );

        assign way_hit[w] = tagv_rd[w].valid && (tagv_rd[w].tag == lookup_tag);
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // an empty way wins over the LRU choice
    assign victim_way   = !tagv_rd[0].valid ? 1'b0 :
                          !tagv_rd[1].valid ? 1'b1 : lru[index_q];
    assign victim_dirty = dirty[victim_way][index_q];
    assign victim_tag   = tagv_rd[victim_way].tag;

    // set of the last lookup, lines up with the RAM outputs
    always_ff @(posedge clk) begin
        if (cmd.rd_en) begin
            index_q <= cmd.index;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (cmd.set_dirty) begin
                dirty[cmd.way][cmd.index] <= 1'b1;
            end else if (cmd.clr_dirty) begin
                dirty[cmd.way][cmd.index] <= 1'b0;
            end
            // the touched way becomes MRU
            if (cmd.touch_lru) begin
                lru[cmd.index] <= ~cmd.way;
            end
        end
    end

endmodule

// File: hw/sync_ram.sv
// --------------------------------------------------
// Single-port synchronous RAM
// --------------------------------------------------
`include "cache_params.svh"

module sync_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = `CACHE_SETS
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    payload_t mem [depth];

    // block RAM contents start cleared
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // read-first: a write returns the old entry
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

// File: hw/cache_pkg.sv
// --------------------------------------------------
// Data cache shared types
// --------------------------------------------------
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0] word_t;

    // bank 0 sits in the low bits
    typedef word_t [`CACHE_BANKS-1:0] block_t;

    // op: 0 read, 1 write
    typedef struct packed {
        logic                       op;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic [3:0]                 wstrb;
        word_t                      wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0] tag;
        logic                    valid;
    } tagv_t;

    typedef struct packed {
        logic [31:0] addr;
        block_t      data;
    } wb_req_t;

    // every action below works on the one way given in the last field
    typedef struct packed {
        logic                      rd_en;
        logic [`CACHE_INDEX_W-1:0] index;
        logic                      fill_we;
        logic [`CACHE_TAG_W-1:0]   fill_tag;
        logic                      set_dirty;
        logic                      clr_dirty;
        logic                      touch_lru;
        logic                      way;
    } tag_cmd_t;

    // replace the enabled bytes of base with those of upd
    function automatic word_t merge_word(word_t base, word_t upd, logic [3:0] be);
        word_t res;
        res = base;
        for (int i = 0; i < `CACHE_WORD_W / 8; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = upd[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: include/cache_params.svh
// --------------------------------------------------
// Data cache geometry
// --------------------------------------------------
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// 256 sets of 16-byte lines, two ways
`define CACHE_SETS      256
`define CACHE_INDEX_W   8
`define CACHE_TAG_W     20
`define CACHE_OFFSET_W  4

// one line is four 32-bit banks
`define CACHE_BANKS     4
`define CACHE_WORD_W    32

`endif
